// ==== Bender.yml ====
package:
  name: fetch_top

sources:
  # RTL, package first
  - logic/fetch_pkg.sv
  - logic/pc_gen.sv
  - logic/instr_rom.sv
  - logic/instr_fields.sv
  - logic/dst_slot.sv
  - logic/fetch_stall.sv
  - logic/fetch_top.sv

  # Testbench
  - target: simulation
    files:
      - bench/tb_fetch_top.sv

// ==== bench/tb_fetch_top.sv ====
module tb_fetch_top
   import fetch_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   //////////////////////////////////////////////////////////////////////
   // Timing and table sizes
   //////////////////////////////////////////////////////////////////////

   localparam int CLK_PERIOD   = 100;
   localparam int DRIVE_DLY    = 5;
   localparam int RESET_CYCLES = 16;
   // Cycles watched after each halt
   localparam int HALT_TAIL    = 8;
   localparam int ROWS         = 33;
   localparam int WATCH_CYCLES = ROWS * 5 + 40;

   // One fetched word per row in the order it leaves fetch
   typedef struct packed {
      logic       first;
      logic       redir;
      logic [3:0] bubbles;
      pc_t        addr;
      instr_t     word;
   } row_t;

   // A row marked first starts a new reset and program load
   // A row marked redir pulses redirect to its addr in the wait before it
   localparam row_t TBL [ROWS] = '{
      // Back to back independent words
      '{1'b1, 1'b0, 4'd0, 16'h0000, 16'h1001},
      '{1'b0, 1'b0, 4'd0, 16'h0002, 16'h1002},
      '{1'b0, 1'b0, 4'd0, 16'h0004, 16'h1003},
      // r1 written, then read through rs right away
      '{1'b0, 1'b0, 4'd0, 16'h0006, 16'h4020},
      '{1'b0, 1'b0, 4'd3, 16'h0008, 16'h4140},
      // One word between producer and consumer
      '{1'b0, 1'b0, 4'd0, 16'h000A, 16'h1004},
      '{1'b0, 1'b0, 4'd2, 16'h000C, 16'h4260},
      // Three between and the hazard is gone
      '{1'b0, 1'b0, 4'd0, 16'h000E, 16'h1005},
      '{1'b0, 1'b0, 4'd0, 16'h0010, 16'h1006},
      '{1'b0, 1'b0, 4'd0, 16'h0012, 16'h1007},
      '{1'b0, 1'b0, 4'd0, 16'h0014, 16'h4380},
      // Two between
      '{1'b0, 1'b0, 4'd0, 16'h0016, 16'h1008},
      '{1'b0, 1'b0, 4'd0, 16'h0018, 16'h1009},
      '{1'b0, 1'b0, 4'd1, 16'h001A, 16'h44A0},
      '{1'b0, 1'b0, 4'd0, 16'h001C, 16'h0000},
      // rt hazard on r1
      '{1'b1, 1'b0, 4'd0, 16'h0000, 16'h1011},
      '{1'b0, 1'b0, 4'd0, 16'h0002, 16'h4020},
      '{1'b0, 1'b0, 4'd3, 16'h0004, 16'hD22C},
      // R-format rd r3 read by rs with one word between
      '{1'b0, 1'b0, 4'd0, 16'h0006, 16'h1012},
      '{1'b0, 1'b0, 4'd2, 16'h0008, 16'hD310},
      // R-format rd r4 read by rt directly after
      '{1'b0, 1'b0, 4'd3, 16'h000A, 16'hD598},
      // Store names r7 but writes nothing
      '{1'b0, 1'b0, 4'd0, 16'h000C, 16'h80E0},
      '{1'b0, 1'b0, 4'd0, 16'h000E, 16'h4740},
      '{1'b0, 1'b0, 4'd0, 16'h0010, 16'h0000},
      // Jump then branch
      '{1'b1, 1'b0, 4'd0, 16'h0000, 16'h1021},
      '{1'b0, 1'b0, 4'd0, 16'h0002, 16'h2010},
      '{1'b0, 1'b0, 4'd3, 16'h0004, 16'h1022},
      '{1'b0, 1'b0, 4'd0, 16'h0006, 16'h60E0},
      '{1'b0, 1'b0, 4'd2, 16'h0008, 16'h1023},
      '{1'b0, 1'b0, 4'd0, 16'h000A, 16'h1024},
      // Jump whose wait gets a redirect to 0x28
      '{1'b0, 1'b0, 4'd0, 16'h000C, 16'h2020},
      '{1'b0, 1'b1, 4'd3, 16'h0028, 16'h1025},
      '{1'b0, 1'b0, 4'd0, 16'h002A, 16'h0000}
   };

   logic      clk;
   logic      rst_n;
   logic      redirect;
   pc_t       redirect_pc;
   logic      load_en;
   rom_addr_t load_addr;
   instr_t    load_data;
   instr_t    instr_out;
   pc_t       next_pc;
   logic      dump;

   fetch_top u_fetch_top (
      .clk         (clk),
      .rst_n       (rst_n),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .load_en     (load_en),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .instr_out   (instr_out),
      .next_pc     (next_pc),
      .dump        (dump)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   task automatic fail_run();
      $display("CHECKS FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         fail_run();
      end
   endtask

   // Drive just after the edge, sample mid cycle
   task automatic step_cycle(input logic redir, input pc_t target);
      @(posedge clk);
      #DRIVE_DLY;
      redirect    = redir;
      redirect_pc = target;
      @(negedge clk);
   endtask

   // Hold reset, load rows first..last-1, release
   task automatic reset_and_load(input int first, input int last);
      int c;
      for (c = 0; c < RESET_CYCLES; c++) begin
         @(posedge clk);
         #DRIVE_DLY;
         rst_n = 1'b0;
         if (first + c < last) begin
            load_en   = 1'b1;
            load_addr = TBL[first + c].addr[8:1];
            load_data = TBL[first + c].word;
         end else begin
            load_en = 1'b0;
         end
      end
      // Last word lands on this edge while still in reset
      @(posedge clk);
      #DRIVE_DLY;
      load_en = 1'b0;
      rst_n   = 1'b1;
      @(negedge clk);
      check_value("instr_out after reset", instr_out, NOP_WORD);
      check_value("next_pc after reset", next_pc, 16'h0000);
      check_value("dump after reset", 16'(dump), 16'h0000);
   endtask

   // Count bubbles up to one past the expected number
   task automatic follow_row(input int idx);
      row_t row;
      int   bub;
      logic seen;
      row  = TBL[idx];
      bub  = 0;
      seen = 1'b0;
      while (!seen && bub <= row.bubbles) begin
         step_cycle(row.redir && (bub == 0), row.addr);
         if (instr_out === NOP_WORD) begin
            bub++;
         end else begin
            seen = 1'b1;
         end
      end
      check_value($sformatf("bubbles before row %0d", idx), 16'(bub), 16'(row.bubbles));
      check_value($sformatf("instr_out row %0d", idx), instr_out, row.word);
      check_value($sformatf("next_pc row %0d", idx), next_pc, row.addr + 16'd2);
   endtask

   // Only bubbles after a halt, PC parked, dump after the delay
   task automatic check_halt_tail(input pc_t halt_addr);
      int i;
      for (i = 1; i <= HALT_TAIL; i++) begin
         step_cycle(1'b0, '0);
         check_value($sformatf("instr_out %0d after halt", i), instr_out, NOP_WORD);
         check_value($sformatf("next_pc %0d after halt", i), next_pc, halt_addr + 16'd2);
         check_value($sformatf("dump %0d after halt", i), 16'(dump),
                     16'(i >= DUMP_DELAY));
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      int r;
      int seg_end;
      int i;
      clk         = 1'b0;
      rst_n       = 1'b0;
      redirect    = 1'b0;
      redirect_pc = '0;
      load_en     = 1'b0;
      load_addr   = '0;
      load_data   = '0;

      r = 0;
      while (r < ROWS) begin
         // Program runs up to the next row marked first
         seg_end = r + 1;
         while (seg_end < ROWS && !TBL[seg_end].first) begin
            seg_end++;
         end
         reset_and_load(r, seg_end);
         for (i = r; i < seg_end; i++) begin
            follow_row(i);
            if (TBL[i].word[15:11] == OP_HALT) begin
               check_halt_tail(TBL[i].addr);
            end
         end
         r = seg_end;
      end

      $display("ALL CHECKS PASSED");
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCH_CYCLES * CLK_PERIOD);
      $display("Timeout: run did not finish within %0d cycles", WATCH_CYCLES);
      fail_run();
   end

endmodule

// ==== logic/dst_slot.sv ====
module dst_slot
   import fetch_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  reg_idx_t in_idx,
   input  logic     in_v,
   input  reg_idx_t rs,
   input  reg_idx_t rt,
   input  logic     rs_v,
   input  logic     rt_v,
   output reg_idx_t slot_idx,
   output logic     slot_v,
   output logic     hit
);

   // Valid flag, cleared on reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         slot_v <= 1'b0;
      end else begin
         slot_v <= in_v;
      end
   end

   // Register index, only meaningful with slot_v
   always_ff @(posedge clk) begin
      slot_idx <= in_idx;
   end

   // Compare against the word now at fetch
   assign hit = slot_v && ((rs_v && (rs == slot_idx)) ||
                           (rt_v && (rt == slot_idx)));

endmodule

// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////////////////////////

   // Byte address, instructions sit on even addresses
   typedef logic [15:0] pc_t;
   typedef logic [15:0] instr_t;
   // Upper five bits of the word
   typedef logic [4:0]  opcode_t;
   typedef logic [2:0]  reg_idx_t;
   // PC bits 8:1
   typedef logic [7:0]  rom_addr_t;

   //////////////////////////////////////////////////////////////////////
   // Encodings
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      CLS_OTHER  = 2'd0,
      CLS_HALT   = 2'd1,
      CLS_JUMP   = 2'd2,
      CLS_BRANCH = 2'd3
   } instr_class_t;

   typedef enum logic [1:0] {
      ST_RUN    = 2'd0,
      ST_WAIT   = 2'd1,
      ST_HALTED = 2'd2
   } fetch_state_t;

   localparam opcode_t OP_HALT  = 5'b00000;
   // Store writes memory, not a register
   localparam opcode_t OP_STORE = 5'b10000;

   // Upper three opcode bits of the control transfer groups
   localparam logic [2:0] CLS_JUMP_BITS   = 3'b001;
   localparam logic [2:0] CLS_BRANCH_BITS = 3'b011;

   // Bubble word pushed into decode
   localparam instr_t NOP_WORD = 16'h0800;

   //////////////////////////////////////////////////////////////////////
   // Sizes and timing
   //////////////////////////////////////////////////////////////////////

   localparam int ROM_WORDS   = 256;
   // One slot per instruction between fetch and writeback
   localparam int HAZ_DEPTH   = 3;
   localparam int JUMP_WAIT   = 3;
   localparam int BRANCH_WAIT = 2;
   localparam int WAIT_CNT_W  = 2;
   // Edges from halt issue to dump
   localparam int DUMP_DELAY  = 5;
   localparam int DUMP_CNT_W  = $clog2(DUMP_DELAY);

endpackage

// ==== logic/fetch_stall.sv ====
module fetch_stall
   import fetch_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  instr_t               word,
   input  instr_class_t         iclass,
   input  logic [HAZ_DEPTH-1:0] hits,
   input  pc_t                  pc_plus2,
   output logic                 issue,
   output logic                 hold,
   output instr_t               instr_out,
   output pc_t                  next_pc,
   output logic                 dump
);

   fetch_state_t          state;
   fetch_state_t          state_nxt;
   logic [WAIT_CNT_W-1:0] wait_cnt;
   logic [WAIT_CNT_W-1:0] wait_cnt_nxt;
   logic [DUMP_CNT_W-1:0] dump_cnt;
   logic                  raw;
   logic                  halt_issue;

   // Any valid slot matching a valid source
   assign raw = |hits;

   // Word leaves fetch only in RUN with no hazard
   assign issue      = (state == ST_RUN) && !raw;
   assign halt_issue = issue && (iclass == CLS_HALT);

   // PC moves only on a non-halt issue
   assign hold = !issue || halt_issue;

   //////////////////////////////////////////////////////////////////////
   // Stall FSM
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      state_nxt    = state;
      wait_cnt_nxt = wait_cnt;
      case (state)
         ST_RUN: begin
            if (issue) begin
               case (iclass)
                  CLS_JUMP: begin
                     state_nxt    = ST_WAIT;
                     wait_cnt_nxt = WAIT_CNT_W'(JUMP_WAIT - 1);
                  end
                  CLS_BRANCH: begin
                     state_nxt    = ST_WAIT;
                     wait_cnt_nxt = WAIT_CNT_W'(BRANCH_WAIT - 1);
                  end
                  CLS_HALT: begin
                     state_nxt = ST_HALTED;
                  end
                  default: begin
                     state_nxt = ST_RUN;
                  end
               endcase
            end
         end
         ST_WAIT: begin
            // Last bubble when the count hits zero
            if (wait_cnt == '0) begin
               state_nxt = ST_RUN;
            end else begin
               wait_cnt_nxt = wait_cnt - 1'b1;
            end
         end
         // Stuck until reset
         ST_HALTED: begin
            state_nxt = ST_HALTED;
         end
         default: begin
            state_nxt = ST_RUN;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= ST_RUN;
         wait_cnt <= '0;
      end else begin
         state    <= state_nxt;
         wait_cnt <= wait_cnt_nxt;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Dump delay
   //////////////////////////////////////////////////////////////////////

   // Loaded on the halt issue edge, dump set once it has drained
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dump_cnt <= '0;
         dump     <= 1'b0;
      end else if (halt_issue) begin
         dump_cnt <= DUMP_CNT_W'(DUMP_DELAY - 1);
      end else if (state == ST_HALTED) begin
         if (dump_cnt != '0) begin
            dump_cnt <= dump_cnt - 1'b1;
         end else begin
            dump <= 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Fetch to decode register
   //////////////////////////////////////////////////////////////////////

   // Updates every cycle, bubble when nothing issues
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         instr_out <= NOP_WORD;
         next_pc   <= '0;
      end else begin
         instr_out <= issue ? word : NOP_WORD;
         next_pc   <= pc_plus2;
      end
   end

endmodule

// ==== logic/fetch_top.sv ====
module fetch_top
   import fetch_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      redirect,
   input  pc_t       redirect_pc,
   input  logic      load_en,
   input  rom_addr_t load_addr,
   input  instr_t    load_data,
   output instr_t    instr_out,
   output pc_t       next_pc,
   output logic      dump
);

   pc_t                  pc;
   pc_t                  pc_plus2;
   instr_t               word;
   reg_idx_t             rs;
   reg_idx_t             rt;
   logic                 rs_v;
   logic                 rt_v;
   reg_idx_t             dst;
   logic                 dst_v;
   instr_class_t         iclass;
   logic                 issue;
   logic                 hold;
   logic [HAZ_DEPTH-1:0] hits;

   // Slot chain outputs, index k is slot k
   reg_idx_t             slot_idx [HAZ_DEPTH];
   logic                 slot_v   [HAZ_DEPTH];

   // PC and memory
   pc_gen u_pc_gen (
      .clk         (clk),
      .rst_n       (rst_n),
      .hold        (hold),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .pc          (pc),
      .pc_plus2    (pc_plus2)
   );

   instr_rom u_instr_rom (
      .clk       (clk),
      .pc        (pc),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .word      (word)
   );

   // Predecode
   instr_fields u_instr_fields (
      .word   (word),
      .rs     (rs),
      .rt     (rt),
      .rs_v   (rs_v),
      .rt_v   (rt_v),
      .dst    (dst),
      .dst_v  (dst_v),
      .iclass (iclass)
   );

   //////////////////////////////////////////////////////////////////////
   // In-flight destination chain
   //////////////////////////////////////////////////////////////////////

   for (genvar k = 0; k < HAZ_DEPTH; k++) begin : g_slot
      reg_idx_t in_idx;
      logic     in_v;

      if (k == 0) begin : g_head
         // Push only what actually left fetch
         assign in_idx = dst;
         assign in_v   = dst_v && issue;
      end else begin : g_link
         assign in_idx = slot_idx[k-1];
         assign in_v   = slot_v[k-1];
      end

      dst_slot u_dst_slot (
         .clk      (clk),
         .rst_n    (rst_n),
         .in_idx   (in_idx),
         .in_v     (in_v),
         .rs       (rs),
         .rt       (rt),
         .rs_v     (rs_v),
         .rt_v     (rt_v),
         .slot_idx (slot_idx[k]),
         .slot_v   (slot_v[k]),
         .hit      (hits[k])
      );
   end

   // Stall control and pipeline register
   fetch_stall u_fetch_stall (
      .clk       (clk),
      .rst_n     (rst_n),
      .word      (word),
      .iclass    (iclass),
      .hits      (hits),
      .pc_plus2  (pc_plus2),
      .issue     (issue),
      .hold      (hold),
      .instr_out (instr_out),
      .next_pc   (next_pc),
      .dump      (dump)
   );

endmodule

// ==== logic/instr_fields.sv ====
module instr_fields
   import fetch_pkg::*;
(
   input  instr_t       word,
   output reg_idx_t     rs,
   output reg_idx_t     rt,
   output logic         rs_v,
   output logic         rt_v,
   output reg_idx_t     dst,
   output logic         dst_v,
   output instr_class_t iclass
);

   opcode_t opcode;
   logic    r_fmt;
   logic    i_fmt;

   assign opcode = word[15:11];

   // Register fields sit at fixed positions
   assign rs = word[10:8];
   assign rt = word[7:5];

   // Three-register ALU group
   assign r_fmt = (word[15:12] == 4'b1101) || (word[15:13] == 3'b111);

   // Immediate groups that write rt, store excluded
   assign i_fmt = ((word[15:14] == 2'b01) || (word[15:14] == 2'b10)) &&
                  (opcode != OP_STORE);

   // rs unused by halt/nop group and plain jumps
   assign rs_v = (word[15:13] != 3'b000) &&
                 ({word[15:13], word[11]} != 4'b0010);

   // rt only read by the R group
   assign rt_v = r_fmt;

   // Destination
   always_comb begin
      dst   = '0;
      dst_v = 1'b0;
      if (r_fmt) begin
         dst   = word[4:2];
         dst_v = 1'b1;
      end else if (i_fmt) begin
         dst   = word[7:5];
         dst_v = 1'b1;
      end
   end

   // Class for the stall controller
   always_comb begin
      if (opcode == OP_HALT) begin
         iclass = CLS_HALT;
      end else if (opcode[4:2] == CLS_JUMP_BITS) begin
         iclass = CLS_JUMP;
      end else if (opcode[4:2] == CLS_BRANCH_BITS) begin
         iclass = CLS_BRANCH;
      end else begin
         iclass = CLS_OTHER;
      end
   end

endmodule

// ==== logic/instr_rom.sv ====
module instr_rom
   import fetch_pkg::*;
(
   input  logic      clk,
   input  pc_t       pc,
   input  logic      load_en,
   input  rom_addr_t load_addr,
   input  instr_t    load_data,
   output instr_t    word
);

   instr_t    mem [ROM_WORDS];
   rom_addr_t rd_addr;

   // Word index, byte offset dropped
   assign rd_addr = pc[8:1];

   // Preload port
   // Only driven while the core sits in reset
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[load_addr] <= load_data;
      end
   end

   // Async read, word valid in the same cycle as pc
   assign word = mem[rd_addr];

endmodule

// ==== logic/pc_gen.sv ====
module pc_gen
   import fetch_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic hold,
   input  logic redirect,
   input  pc_t  redirect_pc,
   output pc_t  pc,
   output pc_t  pc_plus2
);

   pc_t pc_nxt;

   // Sequential address, one word ahead
   assign pc_plus2 = pc + pc_t'(2);

   // Next PC select
   always_comb begin
      if (redirect) begin
         // Later stage wins over any stall
         pc_nxt = redirect_pc;
      end else if (hold) begin
         pc_nxt = pc;
      end else begin
         pc_nxt = pc_plus2;
      end
   end

   // PC register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= '0;
      end else begin
         pc <= pc_nxt;
      end
   end

endmodule

// ==== verilog.f ====
logic/fetch_pkg.sv
logic/pc_gen.sv
logic/instr_rom.sv
logic/instr_fields.sv
logic/dst_slot.sv
logic/fetch_stall.sv
logic/fetch_top.sv
bench/tb_fetch_top.sv
